// File: dv/tagger_vectors.txt
// kind 1 hit : gap in cycles, channel pattern (bit 4 set runs the hit with capture off)
// kind 2 pps : period in cycles, expected K word in the K write; kind 0 ends the list
1 0000000a 00000001
1 0000000c 00000002
1 00000009 00000004
1 00000014 00000008
1 0000000a 00000011  // capture off, no record
1 0000000f 00000001
1 0000000a 0000000f  // all four channels, equal tags
1 0000000b 00000005
1 00000008 0000000a
1 0000000d 00000006
1 0000000a 00000009  // records 16 and 17, second lands at address 0
1 0000000e 00000014  // capture off, no record
1 00000009 0000000b
2 000003e8 7fffffd6  // 1000, on target
2 000003e7 80001511  // 999, short by 1
2 000003eb 7fffd560  // 1003, long by 3
2 000005dc 7fd65e24  // 1500, long by 500
2 00000834 7fd65e24  // 2100, error 1100 over limit, K held
2 000002bc 7fef3f48  // 700, short by 300
2 000007d0 7f9c50d0  // 2000, long by 1000 at the limit
0 00000000 00000000

// File: filelist.f
design/tagger_pkg.sv
design/discipline_pkg.sv
design/hit_capture.sv
design/tag_writer.sv
design/tag_buffer.sv
design/pps_discipline.sv
design/reconfig_sequencer.sv
design/time_tagger_top.sv
dv/tb_time_tagger.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0
TOP       ?= tb_time_tagger
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: dv/tb_time_tagger.sv
//==========================================================
// time tagger testbench
// replays hit patterns and pps periods from the vector
// file, checks stored records and pll management writes
//==========================================================
`timescale 1ns/10ps

module tb_time_tagger;

  import tagger_pkg::*;
  import discipline_pkg::*;

  logic                       clock_100;
  logic                       hps_fpga_reset_n;
  logic                       capture_enable;
  logic [num_channels-1:0]    hit_in;
  logic [3:0]                 rd_addr;            // depth 16 buffer
  logic [record_width-1:0]    rd_data;
  logic                       half_toggle;
  logic                       pps_in;
  logic                       mgmt_waitrequest;
  logic                       mgmt_write;
  logic [mgmt_addr_width-1:0] mgmt_address;
  logic [mgmt_data_width-1:0] mgmt_writedata;

  logic [31:0]                vec [0:191];        // kind, a, b per entry
  logic [29:0]                en_count;           // edges with capture on
  logic [29:0]                tag_offset;         // sync delay in tag counts
  logic                       have_offset;
  logic [1:0]                 last_ch;            // arbiter rotation origin
  logic [3:0]                 wr_model;           // next record address
  int                         total_records;
  int                         cyc = 0;
  int                         last_rise;
  logic                       writes_allowed;     // set at second pps edge
  logic [mgmt_addr_width-1:0] addr_q [$];         // observed mgmt writes
  logic [mgmt_data_width-1:0] data_q [$];

  time_tagger_top #(.buf_addr_width(4), .target_count(1000)) u_dut (
    .clock_100        (clock_100),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .capture_enable   (capture_enable),
    .hit_in           (hit_in),
    .rd_addr          (rd_addr),
    .rd_data          (rd_data),
    .half_toggle      (half_toggle),
    .pps_in           (pps_in),
    .mgmt_waitrequest (mgmt_waitrequest),
    .mgmt_write       (mgmt_write),
    .mgmt_address     (mgmt_address),
    .mgmt_writedata   (mgmt_writedata)
  );

  initial
  begin
    clock_100 = 1'b0;
    forever #4 clock_100 = ~clock_100;   // 125 MHz sim clock
  end

  always @(posedge clock_100)
  begin
    cyc <= cyc + 1;
    if (!hps_fpga_reset_n)
      en_count <= '0;
    else if (capture_enable)
      en_count <= en_count + 30'd1;      // tag only runs while capturing
  end

  //==========================================================
  // checks
  //==========================================================
  task automatic fail_run(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected)
    begin
      $display("Error at %0t: %s expected %h actual %h", $time, name, expected, actual);
      $display("test failed");
      $fatal(1);
    end
  endtask

  // mgmt bus monitor
  always @(negedge clock_100)
  begin
    if (hps_fpga_reset_n && mgmt_write)
    begin
      if (!writes_allowed)
        fail_run("management write seen before the second pps edge");
      else if (mgmt_waitrequest)
        fail_run("management write strobe while waitrequest was high");
      else
      begin
        addr_q.push_back(mgmt_address);
        data_q.push_back(mgmt_writedata);
      end
    end
  end

  //==========================================================
  // tagger path
  //==========================================================
  task automatic read_record(input logic [3:0] addr, output logic [31:0] data);
    @(posedge clock_100);
    rd_addr <= addr;
    @(posedge clock_100);                 // registered read
    @(negedge clock_100);
    data = rd_data;
  endtask

  task automatic collect_records(input logic [3:0] pat, input logic [29:0] stamp);
    logic [31:0] rec;
    logic [1:0]  origin;
    logic [1:0]  ch;
    origin = last_ch;
    for (int i = 1; i <= num_channels; i++)
    begin
      ch = origin + 2'(i);                // rotate from last grant
      if (pat[ch])
      begin
        read_record(wr_model, rec);
        check_value("record channel", {30'd0, ch}, {30'd0, rec[31:30]});
        if (!have_offset)
        begin
          tag_offset  = rec[29:0] - stamp;   // fixed sync delay
          have_offset = 1'b1;
        end
        check_value("record tag", {2'b00, stamp + tag_offset}, {2'b00, rec[29:0]});
        last_ch       = ch;
        wr_model      = wr_model + 4'd1;     // wraps to 0 after 16
        total_records = total_records + 1;
      end
    end
    // one flip per 8 records
    check_value("half_toggle", 32'(total_records / 8 % 2), {31'd0, half_toggle});
  endtask

  task automatic drive_hits(input int gap, input logic [4:0] pat);
    logic [29:0] stamp;
    @(posedge clock_100);
    if (pat[4])
      capture_enable <= 1'b0;             // hit below must leave no record
    repeat (gap) @(posedge clock_100);
    hit_in <= pat[3:0];
    stamp   = en_count;
    repeat (2) @(posedge clock_100);
    hit_in <= '0;
    repeat (8) @(posedge clock_100);      // sync, edge and up to four writes
    if (pat[4])
      capture_enable <= 1'b1;
    else
      collect_records(pat[3:0], stamp);
  endtask

  //==========================================================
  // pps path
  //==========================================================
  task automatic emit_pps;
    int hold;
    hold = 4 + int'($urandom() % 32'd16);
    pps_in           <= 1'b1;
    mgmt_waitrequest <= 1'b1;             // pll busy for a random stretch
    last_rise         = cyc;
    repeat (hold) @(posedge clock_100);
    pps_in           <= 1'b0;
    mgmt_waitrequest <= 1'b0;
  endtask

  task automatic wait_writes(input logic [31:0] k_exp);
    int                         guard;
    logic [mgmt_addr_width-1:0] addr;
    logic [mgmt_data_width-1:0] data;
    guard = 0;
    while (addr_q.size() < 3)
    begin
      @(posedge clock_100);
      guard = guard + 1;
      if (guard > 64)
        fail_run("timeout waiting for the three management writes after a pps edge");
    end
    addr = addr_q.pop_front();
    data = data_q.pop_front();
    check_value("mgmt_address", 32'd0, 32'(addr));   // mode
    check_value("mgmt_writedata", 32'd0, data);
    addr = addr_q.pop_front();
    data = data_q.pop_front();
    check_value("mgmt_address", 32'd7, 32'(addr));   // fractional K
    check_value("mgmt_writedata", k_exp, data);
    addr = addr_q.pop_front();
    data = data_q.pop_front();
    check_value("mgmt_address", 32'd2, 32'(addr));   // start
    check_value("mgmt_writedata", 32'd0, data);
  endtask

  //==========================================================
  // main sequence
  //==========================================================
  initial
  begin
    logic [7:0] idx;
    int         pps_seen;
    hps_fpga_reset_n <= 1'b0;
    capture_enable   <= 1'b0;
    hit_in           <= '0;
    rd_addr          <= '0;
    pps_in           <= 1'b0;
    mgmt_waitrequest <= 1'b0;
    writes_allowed   = 1'b0;
    have_offset      = 1'b0;
    tag_offset       = '0;
    last_ch          = 2'd3;              // channel 0 first after reset
    wr_model         = '0;
    total_records    = 0;
    last_rise        = 0;
    pps_seen         = 0;
    idx              = '0;
    void'($urandom(32'h47b7c8a5));
    $readmemh("dv/tagger_vectors.txt", vec);
    repeat (2) @(posedge clock_100);
    hps_fpga_reset_n <= 1'b1;
    capture_enable   <= 1'b1;
    @(negedge clock_100);
    check_value("mgmt_write", 32'd0, {31'd0, mgmt_write});
    check_value("half_toggle", 32'd0, {31'd0, half_toggle});
    while (idx < 8'd190 && vec[idx] != 32'd0)
    begin
      if (vec[idx] == 32'd1)
        drive_hits(int'(vec[idx + 8'd1]), vec[idx + 8'd2][4:0]);
      else
      begin
        if (pps_seen == 0)
        begin
          @(posedge clock_100);
          emit_pps();                     // first edge only starts the count
        end
        do
          @(posedge clock_100);
        while (cyc - last_rise < int'(vec[idx + 8'd1]));
        writes_allowed = 1'b1;            // next edge may update K
        emit_pps();
        wait_writes(vec[idx + 8'd2]);
        pps_seen = pps_seen + 1;
      end
      idx = idx + 8'd3;
    end
    repeat (20) @(posedge clock_100);     // let any stray strobe show up
    if (addr_q.size() != 0)
      fail_run("extra management write after the last sequence");
    else
    begin
      $display("test passed");
      $finish;
    end
  end

endmodule

// File: design/time_tagger_top.sv
//==========================================================
// time tagger top level
// four capture channels sharing one tag buffer, plus the
// pps loop that retunes the fractional pll
//==========================================================
`timescale 1ns/10ps

module time_tagger_top
#(
  parameter int          buf_addr_width = 15,
  parameter int unsigned target_count   = 100000000
)
(
  input  logic                                       clock_100,
  input  logic                                       hps_fpga_reset_n,
  input  logic                                       capture_enable,
  input  logic [tagger_pkg::num_channels-1:0]        hit_in,
  input  logic [buf_addr_width-1:0]                  rd_addr,
  output logic [tagger_pkg::record_width-1:0]        rd_data,
  output logic                                       half_toggle,
  input  logic                                       pps_in,
  input  logic                                       mgmt_waitrequest,
  output logic                                       mgmt_write,
  output logic [discipline_pkg::mgmt_addr_width-1:0] mgmt_address,
  output logic [discipline_pkg::mgmt_data_width-1:0] mgmt_writedata
);

  import tagger_pkg::*;
  import discipline_pkg::*;

  logic [num_channels-1:0] hit_pending;
  logic [num_channels-1:0] hit_grant;
  tag_t [num_channels-1:0] hit_tags;
  tag_t                    current_tag;
  logic                    buf_we;
  logic [buf_addr_width-1:0] buf_waddr;
  logic [record_width-1:0] buf_wdata;
  logic [k_width-1:0]      k_word;
  logic                    k_update;

  //========================================================
  // time tagger path
  //========================================================
  for (genvar ch = 0; ch < num_channels; ch++)
  begin : g_chan
    hit_capture u_hit_capture (
      .clock_100        (clock_100),
      .hps_fpga_reset_n (hps_fpga_reset_n),
      .hit_in           (hit_in[ch]),
      .capture_enable   (capture_enable),
      .current_tag      (current_tag),       // same tag for all channels
      .hit_grant        (hit_grant[ch]),
      .hit_pending      (hit_pending[ch]),
      .hit_tag          (hit_tags[ch])
    );
  end

  tag_writer #(.buf_addr_width(buf_addr_width)) u_tag_writer (
    .clock_100        (clock_100),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .capture_enable   (capture_enable),
    .hit_pending      (hit_pending),
    .hit_tags         (hit_tags),
    .current_tag      (current_tag),
    .hit_grant        (hit_grant),
    .buf_we           (buf_we),
    .buf_waddr        (buf_waddr),
    .buf_wdata        (buf_wdata),
    .half_toggle      (half_toggle)         // processor copies the full half
  );

  tag_buffer #(.buf_addr_width(buf_addr_width)) u_tag_buffer (
    .clock_100 (clock_100),
    .buf_we    (buf_we),
    .buf_waddr (buf_waddr),
    .buf_wdata (buf_wdata),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data)
  );

  //========================================================
  // pps discipline path
  //========================================================
  pps_discipline #(.target_count(target_count)) u_pps_discipline (
    .clock_100        (clock_100),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .pps_in           (pps_in),
    .k_word           (k_word),
    .k_update         (k_update)
  );

  reconfig_sequencer u_reconfig_sequencer (
    .clock_100        (clock_100),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .k_word           (k_word),
    .k_update         (k_update),
    .mgmt_waitrequest (mgmt_waitrequest),
    .mgmt_write       (mgmt_write),
    .mgmt_address     (mgmt_address),       // to pll reconfig block
    .mgmt_writedata   (mgmt_writedata)
  );

endmodule

// File: design/reconfig_sequencer.sv
//==========================================================
// pll reconfig sequencer
// after each K update writes mode, K and start registers
// on the management bus, one strobe every other cycle
//==========================================================
`timescale 1ns/10ps

module reconfig_sequencer
(
  input  logic                                       clock_100,
  input  logic                                       hps_fpga_reset_n,
  input  logic [discipline_pkg::k_width-1:0]         k_word,
  input  logic                                       k_update,
  input  logic                                       mgmt_waitrequest,
  output logic                                       mgmt_write,
  output logic [discipline_pkg::mgmt_addr_width-1:0] mgmt_address,
  output logic [discipline_pkg::mgmt_data_width-1:0] mgmt_writedata
);

  import discipline_pkg::*;

  //========================================================
  // fsm encoding
  //========================================================
  localparam logic [2:0] st_idle       = 3'd0;
  localparam logic [2:0] st_wait       = 3'd1;   // hold off on waitrequest
  localparam logic [2:0] st_mode_wr    = 3'd2;
  localparam logic [2:0] st_mode_done  = 3'd3;
  localparam logic [2:0] st_k_wr       = 3'd4;
  localparam logic [2:0] st_k_done     = 3'd5;
  localparam logic [2:0] st_start_wr   = 3'd6;
  localparam logic [2:0] st_start_done = 3'd7;

  logic [2:0]         state;
  logic [k_width-1:0] k_hold;   // K captured at update

  always_ff @(posedge clock_100)
  begin
    if (state == st_idle && k_update)
      k_hold <= k_word;
  end

  always_ff @(posedge clock_100 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      state          <= st_idle;
      mgmt_write     <= 1'b0;
      mgmt_address   <= '0;
      mgmt_writedata <= '0;
    end
    else
    begin
      case (state)
        st_idle:
          if (k_update)
            state <= st_wait;   // updates while busy are dropped
        st_wait:
          if (!mgmt_waitrequest)
          begin
            mgmt_address   <= reg_mode_addr;   // set up before strobe
            mgmt_writedata <= '0;
            state          <= st_mode_wr;
          end
        st_mode_wr:
        begin
          mgmt_write <= 1'b1;
          state      <= st_mode_done;
        end
        st_mode_done:
        begin
          mgmt_write     <= 1'b0;
          mgmt_address   <= reg_k_addr;
          mgmt_writedata <= mgmt_data_width'(k_hold);
          state          <= st_k_wr;
        end
        st_k_wr:
        begin
          mgmt_write <= 1'b1;
          state      <= st_k_done;
        end
        st_k_done:
        begin
          mgmt_write     <= 1'b0;
          mgmt_address   <= reg_start_addr;
          mgmt_writedata <= '0;
          state          <= st_start_wr;
        end
        st_start_wr:
        begin
          mgmt_write <= 1'b1;   // kicks off the reconfig
          state      <= st_start_done;
        end
        default:
        begin
          mgmt_write <= 1'b0;   // address and data stay put
          state      <= st_idle;
        end
      endcase
    end
  end

endmodule

// File: design/pps_discipline.sv
//==========================================================
// pps discipline loop
// counts clock cycles per pps period, compares with the
// target and steers the fractional pll K word
//==========================================================
`timescale 1ns/10ps

module pps_discipline
#(
  parameter int unsigned target_count = 100000000
)
(
  input  logic                               clock_100,
  input  logic                               hps_fpga_reset_n,
  input  logic                               pps_in,
  output logic [discipline_pkg::k_width-1:0] k_word,
  output logic                               k_update
);

  import discipline_pkg::*;

  localparam logic [count_width-1:0] target = count_width'(target_count);

  logic [1:0]             sync_q;      // pps synchronizer
  logic                   prev_q;
  logic                   pps_rise;
  logic                   started;     // first edge seen
  logic [count_width-1:0] period_q;    // cycles since last edge
  logic                   is_short;    // clock slow, raise K
  logic [count_width-1:0] error;
  logic [k_width-1:0]     correction;

  assign pps_rise   = sync_q[1] & ~prev_q;
  assign is_short   = period_q < target;
  assign error      = is_short ? (target - period_q) : (period_q - target);   // abs
  assign correction = k_width'(k_gain * error);

  always_ff @(posedge clock_100 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      sync_q   <= 2'b00;
      prev_q   <= 1'b0;
      started  <= 1'b0;
      period_q <= '0;
      k_word   <= k_reset_value;
      k_update <= 1'b0;
    end
    else
    begin
      sync_q   <= {sync_q[0], pps_in};
      prev_q   <= sync_q[1];
      k_update <= 1'b0;
      if (pps_rise)
      begin
        period_q <= count_width'(1);   // edge cycle counts as the first
        started  <= 1'b1;
        if (started)
        begin
          k_update <= 1'b1;
          if (error <= count_width'(max_error))
            k_word <= is_short ? (k_word + correction) : (k_word - correction);
        end
      end
      else
        period_q <= period_q + 1'b1;
    end
  end

endmodule

// File: design/tag_buffer.sv
//==========================================================
// tag buffer
// simple dual-port record memory, one write port from the
// tag writer and a registered read port for the processor
//==========================================================
`timescale 1ns/10ps

module tag_buffer
#(
  parameter int buf_addr_width = 15
)
(
  input  logic                                clock_100,
  input  logic                                buf_we,
  input  logic [buf_addr_width-1:0]           buf_waddr,
  input  logic [tagger_pkg::record_width-1:0] buf_wdata,
  input  logic [buf_addr_width-1:0]           rd_addr,
  output logic [tagger_pkg::record_width-1:0] rd_data
);

  logic [tagger_pkg::record_width-1:0] mem [2**buf_addr_width];   // block ram

  always_ff @(posedge clock_100)
  begin
    if (buf_we)
      mem[buf_waddr] <= buf_wdata;
    rd_data <= mem[rd_addr];   // one cycle read latency
  end

endmodule

// File: design/tag_writer.sv
//==========================================================
// tag writer
// time tag counter, round-robin pick of one pending
// channel per cycle, buffer write pointer and half toggle
//==========================================================
`timescale 1ns/10ps

module tag_writer
#(
  parameter int buf_addr_width = 15
)
(
  input  logic                                      clock_100,
  input  logic                                      hps_fpga_reset_n,
  input  logic                                      capture_enable,
  input  logic [tagger_pkg::num_channels-1:0]       hit_pending,
  input  tagger_pkg::tag_t [tagger_pkg::num_channels-1:0] hit_tags,
  output tagger_pkg::tag_t                          current_tag,
  output logic [tagger_pkg::num_channels-1:0]       hit_grant,
  output logic                                      buf_we,
  output logic [buf_addr_width-1:0]                 buf_waddr,
  output logic [tagger_pkg::record_width-1:0]       buf_wdata,
  output logic                                      half_toggle
);

  import tagger_pkg::*;

  chan_t                     last_grant;    // rotation origin
  chan_t                     grant_chan;
  logic                      grant_valid;
  logic [buf_addr_width-1:0] wr_ptr;
  logic                      half_end;      // pointer at last slot of a half

  //========================================================
  // round-robin arbiter
  //========================================================
  always_comb
  begin
    grant_valid = 1'b0;
    grant_chan  = last_grant;
    for (int i = 1; i <= num_channels; i++)
    begin
      if (!grant_valid && hit_pending[chan_t'(last_grant + i)])   // start after last
      begin
        grant_valid = 1'b1;
        grant_chan  = chan_t'(last_grant + i);
      end
    end
  end

  assign hit_grant = grant_valid ? (num_channels'(1) << grant_chan) : '0;   // one-hot

  //========================================================
  // buffer write side
  //========================================================
  assign buf_we    = grant_valid;
  assign buf_waddr = wr_ptr;
  assign buf_wdata = {grant_chan, hit_tags[grant_chan]};   // chan on top, tag below
  assign half_end  = &wr_ptr[buf_addr_width-2:0];          // 7 or 15 for depth 16

  always_ff @(posedge clock_100 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      current_tag <= '0;
      last_grant  <= chan_t'(num_channels - 1);   // channel 0 first
      wr_ptr      <= '0;
      half_toggle <= 1'b0;
    end
    else
    begin
      if (capture_enable)
        current_tag <= current_tag + 1'b1;   // runs only while capturing
      if (grant_valid)
      begin
        last_grant <= grant_chan;
        wr_ptr     <= wr_ptr + 1'b1;         // wraps over the whole buffer
        if (half_end)
          half_toggle <= ~half_toggle;       // one half is full
      end
    end
  end

endmodule

// File: design/hit_capture.sv
//==========================================================
// hit capture channel
// synchronizes one detector input, finds its rising edge
// and holds the hit with its tag until granted
//==========================================================
`timescale 1ns/10ps

module hit_capture
(
  input  logic              clock_100,
  input  logic              hps_fpga_reset_n,
  input  logic              hit_in,           // async detector pulse
  input  logic              capture_enable,
  input  tagger_pkg::tag_t  current_tag,
  input  logic              hit_grant,        // one cycle from tag_writer
  output logic              hit_pending,
  output tagger_pkg::tag_t  hit_tag
);

  logic [1:0] sync_q;   // two-flop synchronizer
  logic       prev_q;   // last synchronized level
  logic       rise;

  assign rise = sync_q[1] & ~prev_q & capture_enable;   // qualified rising edge

  always_ff @(posedge clock_100 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      sync_q      <= 2'b00;
      prev_q      <= 1'b0;
      hit_pending <= 1'b0;
    end
    else
    begin
      sync_q <= {sync_q[0], hit_in};
      prev_q <= sync_q[1];
      if (rise && !hit_pending)
        hit_pending <= 1'b1;   // new hit, a still pending channel drops it
      else if (hit_grant)
        hit_pending <= 1'b0;   // record went out this cycle
    end
  end

  // tag is payload, only loaded with a new hit
  always_ff @(posedge clock_100)
  begin
    if (rise && !hit_pending)
      hit_tag <= current_tag;
  end

endmodule

// File: design/discipline_pkg.sv
//==========================================================
// pps discipline package
// widths, loop gain, error limit and pll reconfig
// register map for the fractional pll K update
//==========================================================
package discipline_pkg;

  localparam int count_width = 32;   // period counter
  localparam int k_width     = 32;   // fractional K word

  localparam logic [k_width-1:0] k_reset_value = 32'd2147483606;   // nominal K

  localparam int k_gain    = 5435;   // K steps per cycle of error
  localparam int max_error = 1000;   // larger errors are skipped

  //========================================================
  // pll reconfig management bus
  //========================================================
  localparam int mgmt_addr_width = 6;
  localparam int mgmt_data_width = 32;

  localparam logic [mgmt_addr_width-1:0] reg_mode_addr  = 6'd0;   // mode register
  localparam logic [mgmt_addr_width-1:0] reg_k_addr     = 6'd7;   // fractional K
  localparam logic [mgmt_addr_width-1:0] reg_start_addr = 6'd2;   // start reconfig

endpackage

// File: design/tagger_pkg.sv
//==========================================================
// time tagger package
// record layout and channel constants shared by the
// capture channels, the tag writer and the tag buffer
//==========================================================
package tagger_pkg;

  //========================================================
  // channels
  //========================================================
  localparam int num_channels = 4;   // detector inputs
  localparam int chan_width   = 2;   // channel field in a record

  //========================================================
  // record
  //========================================================
  localparam int tag_width    = 30;                       // free-running tag
  localparam int record_width = chan_width + tag_width;   // 32, chan on top

  typedef logic [chan_width-1:0] chan_t;   // channel number
  typedef logic [tag_width-1:0]  tag_t;    // time tag

endpackage
